/* filelist.f */
logic/tube_bus_pkg.sv
logic/tube_disp_pkg.sv
logic/tube_if.sv
logic/tube_axil_slave.sv
logic/tube_reg_bank.sv
logic/tube_scan.sv
logic/tube_top.sv
bench/tube_tb.sv

/* bench/tube_tb.sv */
`timescale 1ns/1ns

module tube_tb;
	import tube_bus_pkg::*;
	import tube_disp_pkg::*;

	localparam int wait_limit = 100; // cycles per handshake or phase step

	// common-anode font, active low, dp off
	localparam seg_t hex_font [16] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0,
		8'h99, 8'h92, 8'h82, 8'hf8,
		8'h80, 8'h90, 8'h88, 8'h83,
		8'hc6, 8'ha1, 8'h86, 8'h8e
	};

	logic                clk;
	logic                rst;
	logic [addr_w-1:0]   awaddr;
	logic                awvalid;
	logic                awready;
	logic [data_w-1:0]   wdata;
	logic [data_w/8-1:0] wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [addr_w-1:0]   araddr;
	logic                arvalid;
	logic                arready;
	logic [data_w-1:0]   rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;
	seg_t                seg_a;
	seg_t                seg_b;
	seg_t                seg_c;
	phase_t              digit_sel;

	integer seed = 29;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_start_errors = 0;

	// register model, follows every accepted write seen on the bus
	logic [data_w-1:0] m_digits = '0;
	logic [3:0]        m_single = '0;
	logic              m_enable = 1'b0;
	logic [3:0]        m_dp = '0;
	logic [31:0]       edges = '0; // clock edges since reset release
	logic              run = 1'b0;

	tube_top u_tube_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_data(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_phase(input string name, input phase_t got, input phase_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// A, B and C patterns packed as {a, b, c}
	function automatic logic [23:0] expected_segs(input logic [31:0] digits,
		input logic [3:0] single, input logic enable, input logic [3:0] dp, input phase_t phase);
		seg_t a;
		seg_t b;
		seg_t c;
		a = seg_blank;
		b = seg_blank;
		c = seg_blank;
		if (enable) begin
			for (int i = 0; i < 4; i++) begin
				if (phase[i]) begin
					a = hex_font[digits[4*i +: 4]];
					b = hex_font[digits[16 + 4*i +: 4]];
					if (dp[i]) begin
						a[7] = 1'b0;
						b[7] = 1'b0;
					end
				end
			end
			c = hex_font[single]; // static digit, never a dp
		end
		return {a, b, c};
	endfunction

	function automatic phase_t model_phase(input logic [31:0] count);
		int idx;
		idx = (count / (scan_div_default + 1)) % digits_per_group;
		return phase_t'(4'b1000 >> idx);
	endfunction

	function automatic logic [data_w-1:0] reg_value(input logic [addr_w-1:0] addr);
		case (addr)
			reg_digits: return m_digits;
			reg_single: return {28'b0, m_single};
			reg_ctrl:   return {24'b0, m_dp, 3'b0, m_enable};
			default:    return '0;
		endcase
	endfunction

	task automatic model_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
		input logic [3:0] strb);
		case (addr)
			reg_digits: begin
				for (int i = 0; i < 4; i++) begin
					if (strb[i])
						m_digits[8*i +: 8] = data[8*i +: 8];
				end
			end
			reg_single: begin
				if (strb[0])
					m_single = data[3:0];
			end
			reg_ctrl: begin
				if (strb[0]) begin
					m_enable = data[0];
					m_dp     = data[7:4];
				end
			end
			default: begin
			end
		endcase
	endtask

	always @(posedge clk) begin
		if (rst) begin
			edges <= '0;
			run   <= 1'b0;
		end else begin
			edges <= edges + 1;
			run   <= 1'b1;
		end
	end

	// compare first, then take in a write accepted in this cycle
	always @(negedge clk) begin
		logic [23:0] exp;
		if (run) begin
			exp = expected_segs(m_digits, m_single, m_enable, m_dp, model_phase(edges));
			check_seg("seg_a", seg_a, exp[23:16]);
			check_seg("seg_b", seg_b, exp[15:8]);
			check_seg("seg_c", seg_c, exp[7:0]);
			check_phase("digit_sel", digit_sel, model_phase(edges));
		end
		if (awvalid && wvalid && awready && wready)
			model_write(awaddr, wdata, wstrb);
	end

	task give_up(input string what);
		$display("timeout: %s", what);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
		input logic [3:0] strb, input int hold, input logic [1:0] exp_resp);
		int n;
		logic [1:0] resp;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!(awready && wready)) begin
			n++;
			if (n > wait_limit)
				give_up("awready and wready never rose for a write");
			@(negedge clk);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid) begin
			n++;
			if (n > wait_limit)
				give_up("bvalid never rose after a write");
			@(negedge clk);
		end
		resp = bresp;
		repeat (hold) begin // bready held low
			@(negedge clk);
			if (!bvalid) begin
				errors++;
				$display("bvalid dropped while bready was low at %0t", $time);
			end
			check_resp("bresp", bresp, resp);
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		check_resp("bresp", resp, exp_resp);
	endtask

	task automatic read_reg(input logic [addr_w-1:0] addr, input int hold,
		input logic [data_w-1:0] exp_data, input logic [1:0] exp_resp);
		int n;
		logic [data_w-1:0] data;
		logic [1:0] resp;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready) begin
			n++;
			if (n > wait_limit)
				give_up("arready never rose for a read");
			@(negedge clk);
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) begin
			n++;
			if (n > wait_limit)
				give_up("rvalid never rose after a read");
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		repeat (hold) begin
			@(negedge clk);
			if (!rvalid) begin
				errors++;
				$display("rvalid dropped while rready was low at %0t", $time);
			end
			check_resp("rresp", rresp, resp);
			check_data("rdata", rdata, data);
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		check_resp("rresp", resp, exp_resp);
		check_data("rdata", data, exp_data);
	endtask

	// wait for each phase step and check it moved one digit to the right
	task automatic follow_scan(input int steps, input logic blank);
		int n;
		phase_t prev;
		prev = digit_sel;
		repeat (steps) begin
			n = 0;
			@(negedge clk);
			while (digit_sel == prev) begin
				n++;
				if (n > wait_limit)
					give_up("digit_sel stopped rotating");
				@(negedge clk);
			end
			check_phase("digit_sel", digit_sel, {prev[0], prev[3:1]});
			if (blank) begin
				check_seg("seg_a", seg_a, seg_blank);
				check_seg("seg_b", seg_b, seg_blank);
				check_seg("seg_c", seg_c, seg_blank);
			end
			prev = digit_sel;
		end
	endtask

	task finish_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	initial begin : main_seq
		logic [data_w-1:0] data;
		logic [data_w-1:0] w_digits;
		logic [data_w-1:0] w_single;
		logic [data_w-1:0] w_ctrl;
		logic [data_w-1:0] expect_word;
		logic [3:0]        strb;
		int                hold;
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_seg("seg_a", seg_a, seg_blank);
		check_seg("seg_b", seg_b, seg_blank);
		check_seg("seg_c", seg_c, seg_blank);
		read_reg(reg_digits, 0, '0, resp_okay);
		read_reg(reg_single, 0, '0, resp_okay);
		read_reg(reg_ctrl, 0, '0, resp_okay);
		finish_test("reset state");

		w_digits = $random(seed);
		w_single = $random(seed);
		w_ctrl   = $random(seed);
		write_reg(reg_digits, w_digits, 4'hf, 0, resp_okay);
		write_reg(reg_single, w_single, 4'hf, 0, resp_okay);
		write_reg(reg_ctrl, w_ctrl, 4'hf, 0, resp_okay);
		read_reg(reg_digits, 0, w_digits, resp_okay);
		read_reg(reg_single, 0, w_single & 32'hf, resp_okay);
		read_reg(reg_ctrl, 0, w_ctrl & 32'hf1, resp_okay);
		data = $random(seed);
		strb = $random(seed);
		if (strb == 4'h0 || strb == 4'hf)
			strb = 4'b0110;
		for (int i = 0; i < 4; i++)
			expect_word[8*i +: 8] = strb[i] ? data[8*i +: 8] : w_digits[8*i +: 8];
		write_reg(reg_digits, data, strb, 0, resp_okay);
		read_reg(reg_digits, 0, expect_word, resp_okay);
		write_reg(reg_single, ~w_single, 4'b1110, 0, resp_okay); // low lane off
		read_reg(reg_single, 0, w_single & 32'hf, resp_okay);
		finish_test("read-back and byte strobes");

		write_reg(12'h00c, $random(seed), 4'hf, 0, resp_slverr);
		read_reg(12'h00c, 0, '0, resp_slverr);
		write_reg(12'h7f0, $random(seed), 4'hf, 0, resp_slverr);
		read_reg(12'h7f0, 0, '0, resp_slverr);
		read_reg(reg_digits, 0, reg_value(reg_digits), resp_okay);
		read_reg(reg_single, 0, reg_value(reg_single), resp_okay);
		read_reg(reg_ctrl, 0, reg_value(reg_ctrl), resp_okay);
		finish_test("unmapped offsets");

		write_reg(reg_digits, $random(seed), 4'hf, 0, resp_okay);
		write_reg(reg_single, $random(seed), 4'hf, 0, resp_okay);
		data = ($random(seed) & 32'hf0) | 32'h1;
		if (data[7:4] == 4'h0)
			data[7:4] = 4'b0101; // keep some dp lit
		write_reg(reg_ctrl, data, 4'hf, 0, resp_okay);
		follow_scan(8, 1'b0);
		finish_test("scan and decode");

		data = $random(seed);
		hold = 1 + ($random(seed) & 7);
		write_reg(reg_digits, data, 4'hf, hold, resp_okay);
		hold = 1 + ($random(seed) & 7);
		read_reg(reg_digits, hold, data, resp_okay);
		read_reg(12'h010, hold, '0, resp_slverr);
		data = $random(seed);
		write_reg(reg_digits, data, 4'hf, 0, resp_okay);
		read_reg(reg_digits, 0, data, resp_okay);
		finish_test("response back-pressure");

		write_reg(reg_ctrl, 32'hf0, 4'hf, 0, resp_okay); // dp set, display off
		follow_scan(4, 1'b1);
		finish_test("blank on disable");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* logic/tube_top.sv */
`timescale 1ns/1ns

module tube_top (
	input  logic                             clk,
	input  logic                             rst,

	input  logic [tube_bus_pkg::addr_w-1:0]   awaddr,
	input  logic                             awvalid,
	output logic                             awready,
	input  logic [tube_bus_pkg::data_w-1:0]   wdata,
	input  logic [tube_bus_pkg::data_w/8-1:0] wstrb,
	input  logic                             wvalid,
	output logic                             wready,
	output logic [1:0]                       bresp,
	output logic                             bvalid,
	input  logic                             bready,
	input  logic [tube_bus_pkg::addr_w-1:0]   araddr,
	input  logic                             arvalid,
	output logic                             arready,
	output logic [tube_bus_pkg::data_w-1:0]   rdata,
	output logic [1:0]                       rresp,
	output logic                             rvalid,
	input  logic                             rready,

	output tube_disp_pkg::seg_t              seg_a,
	output tube_disp_pkg::seg_t              seg_b,
	output tube_disp_pkg::seg_t              seg_c,
	output tube_disp_pkg::phase_t            digit_sel
);
	import tube_disp_pkg::*;

	reg_access_if regs ();
	disp_state_if disp ();

	tube_axil_slave u_axil_slave (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.regs    (regs.master)
	);

	tube_reg_bank u_reg_bank (
		.clk  (clk),
		.rst  (rst),
		.regs (regs.slave),
		.disp (disp.source)
	);

	tube_scan #(
		.scan_div (scan_div_default)
	) u_scan (
		.clk       (clk),
		.rst       (rst),
		.disp      (disp.sink),
		.seg_a     (seg_a),
		.seg_b     (seg_b),
		.seg_c     (seg_c),
		.digit_sel (digit_sel)
	);

endmodule

/* logic/tube_scan.sv */
`timescale 1ns/1ns

module tube_scan #(
	parameter int unsigned scan_div = tube_disp_pkg::scan_div_default
) (
	input  logic                  clk,
	input  logic                  rst,
	disp_state_if.sink            disp,
	output tube_disp_pkg::seg_t   seg_a,
	output tube_disp_pkg::seg_t   seg_b,
	output tube_disp_pkg::seg_t   seg_c,
	output tube_disp_pkg::phase_t digit_sel
);
	import tube_disp_pkg::*;

	phase_t      phase;
	logic [31:0] cnt; // wide enough for any scan_div
	logic [3:0]  nib_a;
	logic [3:0]  nib_b;
	logic        dp;

	// scan divider and phase rotation, 1000 -> 0100 -> 0010 -> 0001
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= scan_div;
			phase <= phase_reset;
		end else if (cnt == 0) begin
			cnt   <= scan_div;
			phase <= {phase[0], phase[digits_per_group-1:1]};
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// the active phase bit picks the nibble at the same index
	always_comb begin
		nib_a = '0;
		nib_b = '0;
		for (int i = 0; i < digits_per_group; i++) begin
			if (phase[i]) begin
				nib_a = disp.digits.banks.bank_a[i];
				nib_b = disp.digits.banks.bank_b[i];
			end
		end
	end

	assign dp = |(phase & disp.dp_mask); // shared by a and b

	// dp is active low, clearing bit 7 lights it
	assign seg_a = disp.enable ? (seg_table[nib_a] & {~dp, 7'h7f}) : seg_blank;
	assign seg_b = disp.enable ? (seg_table[nib_b] & {~dp, 7'h7f}) : seg_blank;
	assign seg_c = disp.enable ? seg_table[disp.single] : seg_blank;

	assign digit_sel = phase;

endmodule

/* logic/tube_reg_bank.sv */
`timescale 1ns/1ns

module tube_reg_bank (
	input  logic          clk,
	input  logic          rst,
	reg_access_if.slave   regs,
	disp_state_if.source  disp
);
	import tube_bus_pkg::*;

	digit_word_u       digits_q;
	logic [3:0]        single_q;
	logic              enable_q;
	logic [3:0]        dp_mask_q;
	logic [data_w-1:0] rd_word;

	// storage, each byte lane only under its strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			digits_q.raw <= '0;
			single_q     <= '0;
			enable_q     <= 1'b0;
			dp_mask_q    <= '0;
		end else if (regs.wr_en) begin
			case (regs.addr)
				reg_digits: begin
					for (int i = 0; i < data_w/8; i++) begin
						if (regs.strb[i])
							digits_q.raw[8*i +: 8] <= regs.wdata[8*i +: 8];
					end
				end
				reg_single: begin
					if (regs.strb[0])
						single_q <= regs.wdata[3:0];
				end
				reg_ctrl: begin
					if (regs.strb[0]) begin
						enable_q  <= regs.wdata[0];
						dp_mask_q <= regs.wdata[7:4];
					end
				end
				default: begin
				end
			endcase
		end
	end

	// decode and read-back, unimplemented bits read as zero
	always_comb begin
		regs.hit = 1'b1;
		rd_word  = '0;
		case (regs.addr)
			reg_digits: rd_word = digits_q.raw;
			reg_single: rd_word = {28'b0, single_q};
			reg_ctrl:   rd_word = {24'b0, dp_mask_q, 3'b0, enable_q};
			default:    regs.hit = 1'b0;
		endcase
	end

	assign regs.rdata = regs.rd_en ? rd_word : '0; // quiet between reads

	assign disp.digits  = digits_q;
	assign disp.single  = single_q;
	assign disp.enable  = enable_q;
	assign disp.dp_mask = dp_mask_q;

endmodule

/* logic/tube_axil_slave.sv */
`timescale 1ns/1ns

module tube_axil_slave (
	input  logic                           clk,
	input  logic                           rst,

	input  logic [tube_bus_pkg::addr_w-1:0] awaddr,
	input  logic                           awvalid,
	output logic                           awready,

	input  logic [tube_bus_pkg::data_w-1:0] wdata,
	input  logic [tube_bus_pkg::data_w/8-1:0] wstrb,
	input  logic                           wvalid,
	output logic                           wready,

	output logic [1:0]                     bresp,
	output logic                           bvalid,
	input  logic                           bready,

	input  logic [tube_bus_pkg::addr_w-1:0] araddr,
	input  logic                           arvalid,
	output logic                           arready,

	output logic [tube_bus_pkg::data_w-1:0] rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready,

	reg_access_if.master                   regs
);
	import tube_bus_pkg::*;

	logic wr_go; // accept cycle of a write, also the wr_en strobe
	logic rd_go;
	logic prefer_rd;
	logic wr_req;
	logic rd_req;
	logic wr_grant;
	logic rd_grant;

	// a direction is blocked while its response is still waiting
	assign wr_req = awvalid && wvalid && !bvalid;
	assign rd_req = arvalid && !rvalid;

	// one register access per cycle, the fairness bit breaks ties
	assign wr_grant = wr_req && !wr_go && !rd_go && !(rd_req && prefer_rd);
	assign rd_grant = rd_req && !wr_go && !rd_go && !(wr_req && !prefer_rd);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_go     <= 1'b0;
			rd_go     <= 1'b0;
			prefer_rd <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			wr_go <= wr_grant;
			rd_go <= rd_grant;

			if (wr_grant)
				prefer_rd <= 1'b1;
			else if (rd_grant)
				prefer_rd <= 1'b0;

			if (wr_go)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;

			if (rd_go)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	// response payload captured in the access cycle
	always_ff @(posedge clk) begin
		if (wr_go)
			bresp <= regs.hit ? resp_okay : resp_slverr;
		if (rd_go) begin
			rresp <= regs.hit ? resp_okay : resp_slverr;
			rdata <= regs.rdata;
		end
	end

	assign awready = wr_go;
	assign wready  = wr_go;
	assign arready = rd_go;

	// aw and w payloads are still held by the master in the accept cycle
	assign regs.wr_en = wr_go;
	assign regs.rd_en = rd_go;
	assign regs.addr  = wr_go ? awaddr : araddr;
	assign regs.wdata = wdata;
	assign regs.strb  = wstrb;

endmodule

/* logic/tube_if.sv */
`timescale 1ns/1ns

// single register access per strobe, decoded by the bank
interface reg_access_if;
	import tube_bus_pkg::*;

	logic              wr_en;
	logic              rd_en;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic [data_w/8-1:0] strb;
	logic [data_w-1:0] rdata;
	logic              hit; // addr maps to a register

	modport master (
		output wr_en, rd_en, addr, wdata, strb,
		input  rdata, hit
	);

	modport slave (
		input  wr_en, rd_en, addr, wdata, strb,
		output rdata, hit
	);

endinterface

// display state held by the register bank
interface disp_state_if;
	import tube_bus_pkg::*;

	digit_word_u digits;
	logic [3:0]  single;
	logic        enable;
	logic [3:0]  dp_mask;

	modport source (
		output digits, single, enable, dp_mask
	);

	modport sink (
		input digits, single, enable, dp_mask
	);

endinterface

/* logic/tube_disp_pkg.sv */
package tube_disp_pkg;

	localparam int digits_per_group = 4;

	// one-hot scan position, bit 3 is the leftmost digit
	typedef logic [digits_per_group-1:0] phase_t;
	localparam phase_t phase_reset = 4'b1000;

	// active low, bit 7 = dp, bits 6:0 = g..a
	typedef logic [7:0] seg_t;
	localparam seg_t seg_blank = 8'hff;

	localparam seg_t seg_table [16] = '{
		8'hc0, // 0
		8'hf9, // 1
		8'ha4, // 2
		8'hb0, // 3
		8'h99, // 4
		8'h92, // 5
		8'h82, // 6
		8'hf8, // 7
		8'h80, // 8
		8'h90, // 9
		8'h88, // a
		8'h83, // b
		8'hc6, // c
		8'ha1, // d
		8'h86, // e
		8'h8e  // f
	};

	// clock cycles per scan step, minus one
	localparam int unsigned scan_div_default = 15;

endpackage

/* logic/tube_bus_pkg.sv */
package tube_bus_pkg;

	localparam int addr_w = 12;
	localparam int data_w = 32;

	// register offsets
	localparam logic [addr_w-1:0] reg_digits = 12'h000;
	localparam logic [addr_w-1:0] reg_single = 12'h004;
	localparam logic [addr_w-1:0] reg_ctrl   = 12'h008;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// bank_a sits in the low half, nibble [3] is the leftmost digit
	typedef struct packed {
		logic [3:0][3:0] bank_b;
		logic [3:0][3:0] bank_a;
	} digit_banks_t;

	// same word as the bus sees it and as the scanner sees it
	typedef union packed {
		logic [data_w-1:0] raw;
		digit_banks_t      banks;
	} digit_word_u;

endpackage
